//--- Makefile
TOOL       = verilator
TOP        = tileDisplayTb
FILELIST   = vlog.f
FLAGS      = --timing --assert
LINT_FLAGS = --lint-only
SIM_FLAGS  = --binary -j 0
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation finished: PASS
FAIL_MSG   = Simulation finished: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tileDisplayTb.sv
`timescale 1ns/100ps

module tileDisplayTb;

	localparam int Width = int'(tilePkg::ScreenWidth);
	localparam int Height = int'(tilePkg::ScreenHeight);
	localparam int PixelCount = Width * Height;
	localparam int BorderW = int'(tilePkg::BorderWidth);
	localparam int LaneW = int'(tilePkg::LaneWidth);
	localparam int TileW = int'(tilePkg::TileWidth);
	localparam int TileH = int'(tilePkg::TileHeight);
	localparam int LastTop = int'(tilePkg::LastTop);
	localparam int NumLanes = 4;
	localparam int InitWrites = tilePkg::NumTiles * TileH * TileW;
	localparam int IdleGap = 100;
	localparam int BurstTimeout = 50000;
	localparam int NumRows = 6;

	typedef struct packed
	{
		logic sw;
		int bursts;
		int hold;
	} stimRow_t;

	// Switch level, drawing bursts to wait for, idle cycles for rows without bursts
	// First burst holds background, initial draw and step 1 back to back
	stimRow_t stimTable [NumRows] = '{
		'{1'b0, 0, 2000},
		'{1'b1, 1, 0},
		'{1'b1, 4, 0},
		'{1'b1, 6, 0},
		'{1'b0, 0, 9000},
		'{1'b1, 3, 0}
	};

	logic CLOCK_50;
	logic rst;
	logic [7:0] SW;
	tilePkg::xCoord_t VGA_X;
	tilePkg::yCoord_t VGA_Y;
	tilePkg::color_t VGA_COLOR;
	logic plot;

	logic [2:0] fb [PixelCount];
	logic [2:0] snapFb [PixelCount];
	logic [2:0] expFb [PixelCount];
	int hits [PixelCount];
	int expLane [tilePkg::NumTiles];
	int expTop [tilePkg::NumTiles];
	int totalWrites;
	int burstWrites;
	int lastBurstWrites;
	int burstCount;
	int idleCount;
	int expWrites;
	int stepNumber;
	int errorCount;
	int timeoutCount;
	logic backgroundDone;
	logic [tilePkg::NumTiles-1:0] wrapMask;

	tileDisplay u_dut
	(
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.SW(SW),
		.VGA_X(VGA_X),
		.VGA_Y(VGA_Y),
		.VGA_COLOR(VGA_COLOR),
		.plot(plot)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	task automatic checkValue(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			errorCount++;
			$display("ERROR: time %0t signal %s actual %0d expected %0d",
				$time, name, actual, expected);
		end
	endtask

	task automatic finishRun();
		$display("Checks done: %0d value errors, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	// Bars repeat every lane plus border, starting at x = 0
	function automatic int bgColor(input int x);
		if ((x % (BorderW + LaneW)) < BorderW)
			return int'(tilePkg::ColorBorder);
		return int'(tilePkg::ColorBlack);
	endfunction

	function automatic int laneLeft(input int lane);
		return BorderW + lane * (LaneW + BorderW);
	endfunction

	task automatic paintRect(input int lane, input int top, input int rows,
		input tilePkg::color_t color);
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < TileW; c++)
				expFb[(top + r) * Width + laneLeft(lane) + c] = color;
		expWrites += rows * TileW;
	endtask

	task automatic paintStart();
		for (int p = 0; p < PixelCount; p++)
			expFb[p] = 3'(bgColor(p % Width));
		expWrites += PixelCount;
		for (int i = 0; i < tilePkg::NumTiles; i++)
			paintRect(expLane[i], expTop[i], TileH, tilePkg::ColorTile);
	endtask

	// Tiles served in order, positions advance together afterwards
	task automatic applyStep();
		int nextLane;
		stepNumber++;
		wrapMask = '0;
		for (int i = 0; i < tilePkg::NumTiles; i++)
		begin
			if (expTop[i] == LastTop)
			begin
				nextLane = (expLane[i] + 1) % NumLanes;
				paintRect(expLane[i], expTop[i], TileH, tilePkg::ColorBlack);
				paintRect(nextLane, 0, TileH, tilePkg::ColorTile);
				expLane[i] = nextLane;
				expTop[i] = 0;
				wrapMask[i] = 1'b1;
			end
			else
			begin
				paintRect(expLane[i], expTop[i], 1, tilePkg::ColorBlack);
				paintRect(expLane[i], expTop[i] + TileH, 1, tilePkg::ColorTile);
				expTop[i] = expTop[i] + 1;
			end
		end
	endtask

	task automatic compareFrame(input logic useSnapshot, input string where);
		int bad;
		int first;
		logic [2:0] seen;
		bad = 0;
		first = 0;
		for (int p = 0; p < PixelCount; p++)
		begin
			seen = useSnapshot ? snapFb[p] : fb[p];
			if (seen !== expFb[p])
			begin
				if (bad == 0)
					first = p;
				bad++;
			end
		end
		if (bad > 0)
		begin
			$display("Framebuffer differs from the model at %0d pixels after %s", bad, where);
			seen = useSnapshot ? snapFb[first] : fb[first];
			checkValue($sformatf("VGA_COLOR at (%0d,%0d)", first % Width, first / Width),
				int'(seen), int'(expFb[first]));
		end
	endtask

	task automatic checkBurst();
		int bad;
		expWrites = 0;
		if (!backgroundDone)
		begin
			paintStart();
			compareFrame(1'b1, "initial draw");
			bad = 0;
			for (int p = 0; p < PixelCount; p++)
				if (hits[p] != 1)
					bad++;
			checkValue("background pixels not written once", bad, 0);
			backgroundDone = 1'b1;
		end
		applyStep();
		checkValue("plot writes in burst", lastBurstWrites, expWrites);
		compareFrame(1'b0, $sformatf("step %0d", stepNumber));
		if (wrapMask[3])
		begin
			// Tile 3 leaves lane 3 and shows up at the top of lane 0
			checkValue("VGA_COLOR at lane 0 row 0", int'(fb[laneLeft(0)]),
				int'(tilePkg::ColorTile));
			checkValue("VGA_COLOR at lane 3 row 119",
				int'(fb[(Height - 1) * Width + laneLeft(3)]), int'(tilePkg::ColorBlack));
		end
	endtask

	task automatic waitBurst();
		int target;
		int cycles;
		target = burstCount + 1;
		cycles = 0;
		while (burstCount < target && cycles < BurstTimeout)
		begin
			@(posedge CLOCK_50);
			cycles++;
		end
		if (burstCount < target)
		begin
			$display("Timeout: no drawing burst finished within %0d cycles", BurstTimeout);
			timeoutCount++;
		end
	endtask

	task automatic runRow(input stimRow_t row);
		int startWrites;
		@(posedge CLOCK_50);
		#1 SW[0] = row.sw;
		if (row.bursts == 0)
		begin
			startWrites = totalWrites;
			repeat (row.hold) @(posedge CLOCK_50);
			checkValue("plot writes while idle", totalWrites - startWrites, 0);
			compareFrame(1'b0, "idle period");
		end
		else
		begin
			for (int b = 0; b < row.bursts && timeoutCount == 0; b++)
			begin
				waitBurst();
				if (timeoutCount == 0)
					checkBurst();
			end
		end
	endtask

	// Framebuffer model fed by every plotted pixel
	always @(negedge CLOCK_50)
	begin
		int idx;
		if (rst)
		begin
			burstWrites = 0;
			idleCount = 0;
		end
		else if (plot)
		begin
			idx = int'(VGA_Y) * Width + int'(VGA_X);
			if (totalWrites < PixelCount)
			begin
				// Background arrives in raster order
				checkValue("VGA_X", int'(VGA_X), totalWrites % Width);
				checkValue("VGA_Y", int'(VGA_Y), totalWrites / Width);
				checkValue("VGA_COLOR", int'(VGA_COLOR), bgColor(totalWrites % Width));
				if (idx < PixelCount)
					hits[idx]++;
			end
			if (idx < PixelCount)
				fb[idx] = VGA_COLOR;
			totalWrites++;
			burstWrites++;
			idleCount = 0;
			if (totalWrites == PixelCount + InitWrites)
				for (int p = 0; p < PixelCount; p++)
					snapFb[p] = fb[p];
		end
		else if (burstWrites > 0)
		begin
			idleCount++;
			if (idleCount > IdleGap)
			begin
				lastBurstWrites = burstWrites;
				burstWrites = 0;
				idleCount = 0;
				burstCount++;
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		SW = '0;
		errorCount = 0;
		timeoutCount = 0;
		totalWrites = 0;
		lastBurstWrites = 0;
		burstCount = 0;
		stepNumber = 0;
		backgroundDone = 1'b0;
		wrapMask = '0;
		for (int p = 0; p < PixelCount; p++)
		begin
			fb[p] = '0;
			snapFb[p] = '0;
			expFb[p] = '0;
			hits[p] = 0;
		end
		for (int i = 0; i < tilePkg::NumTiles; i++)
		begin
			expLane[i] = i;
			expTop[i] = i * tilePkg::StartStagger;
		end
		repeat (4) @(posedge CLOCK_50);
		#1 rst = 1'b0;
		for (int r = 0; r < NumRows && timeoutCount == 0; r++)
			runRow(stimTable[r]);
		finishRun();
	end

endmodule

//--- dv/tileDisplay_assertions.sv
`timescale 1ns/100ps

module tileDisplayChecks
(
	input logic CLOCK_50,
	input logic rst,
	input logic spanValid,
	input logic plot,
	input tilePkg::xCoord_t VGA_X,
	input tilePkg::yCoord_t VGA_Y,
	input logic stepAck
);

	// Accepted span starts next cycle or queues behind the active one
	spanAccepted: assert property (@(posedge CLOCK_50) disable iff (rst)
		spanValid |=> plot)
		else $error("accepted span did not keep the pixel output busy");

	pixelOnScreen: assert property (@(posedge CLOCK_50) disable iff (rst)
		plot |-> (VGA_X < tilePkg::ScreenWidth && VGA_Y < tilePkg::ScreenHeight))
		else $error("plotted pixel lies outside the screen");

	ackSingleCycle: assert property (@(posedge CLOCK_50) disable iff (rst)
		stepAck |=> !stepAck)
		else $error("stepAck held longer than one cycle");

	plotLowAfterReset: assert property (@(posedge CLOCK_50)
		rst |=> !plot)
		else $error("plot high in the cycle after reset");

endmodule

bind tileDisplay tileDisplayChecks u_checks
(
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.spanValid(spanValid),
	.plot(plot),
	.VGA_X(VGA_X),
	.VGA_Y(VGA_Y),
	.stepAck(stepAck)
);

//--- logic/drawSequencer.sv
`timescale 1ns/100ps

module drawSequencer
(
	input logic CLOCK_50,
	input logic rst,
	input logic running,
	input logic stepPending,
	input tilePkg::tileArray_t tiles,
	input logic spanBusy,
	output tilePkg::spanCmd_t span,
	output logic spanValid,
	output logic stepAck
);

	tilePkg::seqState_t state;
	tilePkg::yCoord_t rowCount;
	logic [3:0] segCount;
	tilePkg::xCoord_t bgX;
	tilePkg::lane_t tileIdx;

	tilePkg::tileState_t curTile;
	logic wholeTile;
	logic lastRow;
	logic lastTile;
	tilePkg::lane_t spanLane;
	tilePkg::yCoord_t spanRow;
	tilePkg::xCoord_t tileX;

	// Span source for the current state
	always_comb
	begin
		curTile = tiles[tileIdx];
		wholeTile = curTile.atBottom || (state == tilePkg::INITDRAW);
		lastRow = wholeTile ? (rowCount == tilePkg::TileHeight - 1'b1) : 1'b1;
		lastTile = (tileIdx == tilePkg::lane_t'(tilePkg::NumTiles - 1));

		spanLane = curTile.lane;
		spanRow = curTile.top + rowCount;
		if (state == tilePkg::DRAW)
		begin
			if (curTile.atBottom)
			begin
				// Redraw at the top of the next lane
				spanLane = curTile.lane + 1'b1;
				spanRow = rowCount;
			end
			else
				spanRow = curTile.top + tilePkg::TileHeight;
		end
		tileX = tilePkg::BorderWidth
			+ spanLane * (tilePkg::LaneWidth + tilePkg::BorderWidth);

		if (state == tilePkg::BACKGROUND)
		begin
			// Odd segments are lanes, even ones are border bars
			span.xStart = bgX;
			span.y = rowCount;
			span.len = segCount[0] ? tilePkg::LaneWidth : tilePkg::BorderWidth;
			span.color = segCount[0] ? tilePkg::ColorBlack : tilePkg::ColorBorder;
		end
		else
		begin
			span.xStart = tileX;
			span.y = spanRow;
			span.len = tilePkg::TileWidth;
			span.color = (state == tilePkg::ERASE) ? tilePkg::ColorBlack : tilePkg::ColorTile;
		end
	end

	assign spanValid = !spanBusy && (state inside {tilePkg::BACKGROUND, tilePkg::INITDRAW,
		tilePkg::ERASE, tilePkg::DRAW});
	assign stepAck = (state == tilePkg::ACK);

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			state <= tilePkg::IDLE;
			rowCount <= '0;
			segCount <= '0;
			bgX <= '0;
			tileIdx <= '0;
		end
		else
		begin
			unique case (state)
				tilePkg::IDLE:
					if (running)
						state <= tilePkg::BACKGROUND;
				tilePkg::BACKGROUND:
					if (spanValid)
					begin
						if (segCount == 4'(2 * tilePkg::NumTiles))
						begin
							segCount <= '0;
							bgX <= '0;
							if (rowCount == tilePkg::ScreenHeight - 1'b1)
							begin
								rowCount <= '0;
								state <= tilePkg::INITDRAW;
							end
							else
								rowCount <= rowCount + 1'b1;
						end
						else
						begin
							segCount <= segCount + 1'b1;
							bgX <= bgX + span.len;
						end
					end
				tilePkg::INITDRAW:
					if (spanValid)
					begin
						rowCount <= lastRow ? '0 : rowCount + 1'b1;
						if (lastRow)
						begin
							tileIdx <= tileIdx + 1'b1;
							if (lastTile)
								state <= tilePkg::WAITSTEP;
						end
					end
				tilePkg::WAITSTEP:
					if (stepPending)
						state <= tilePkg::ERASE;
				tilePkg::ERASE:
					if (spanValid)
					begin
						rowCount <= lastRow ? '0 : rowCount + 1'b1;
						if (lastRow)
							state <= tilePkg::DRAW;
					end
				tilePkg::DRAW:
					if (spanValid)
					begin
						rowCount <= lastRow ? '0 : rowCount + 1'b1;
						if (lastRow)
						begin
							// Index wraps back to tile 0 after the last one
							tileIdx <= tileIdx + 1'b1;
							state <= lastTile ? tilePkg::ACK : tilePkg::ERASE;
						end
					end
				tilePkg::ACK:
					state <= tilePkg::WAITSTEP;
				default:
					state <= tilePkg::IDLE;
			endcase
		end
	end

endmodule

//--- logic/spanRasterizer.sv
`timescale 1ns/100ps

module spanRasterizer
(
	input logic CLOCK_50,
	input logic rst,
	input tilePkg::spanCmd_t span,
	input logic spanValid,
	output logic spanBusy,
	output tilePkg::xCoord_t VGA_X,
	output tilePkg::yCoord_t VGA_Y,
	output tilePkg::color_t VGA_COLOR,
	output logic plot
);

	tilePkg::pixel_t pixOut;
	tilePkg::spanLen_t remaining;
	logic pendValid;
	tilePkg::spanCmd_t pendSpan;

	logic activeMore;
	logic loadNext;
	tilePkg::spanCmd_t nextSpan;

	// Pixels still owed by the span on the output
	assign activeMore = plot && (remaining != '0);
	assign spanBusy = pendValid;

	// Buffered span goes first, otherwise take the incoming one directly
	assign nextSpan = pendValid ? pendSpan : span;
	assign loadNext = !activeMore && (pendValid || spanValid);

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			plot <= 1'b0;
			remaining <= '0;
			pendValid <= 1'b0;
		end
		else
		begin
			if (activeMore)
				remaining <= remaining - 1'b1;
			else if (loadNext)
				remaining <= nextSpan.len - 1'b1;
			plot <= activeMore || loadNext;

			if (spanValid && activeMore)
				pendValid <= 1'b1;
			else if (loadNext && pendValid)
				pendValid <= 1'b0;
		end
	end

	// Pixel and buffer payload
	always_ff @(posedge CLOCK_50)
	begin
		if (activeMore)
			pixOut.x <= pixOut.x + 1'b1;
		else if (loadNext)
		begin
			pixOut.x <= nextSpan.xStart;
			pixOut.y <= nextSpan.y;
			pixOut.color <= nextSpan.color;
		end

		if (spanValid && activeMore)
			pendSpan <= span;
	end

	assign VGA_X = pixOut.x;
	assign VGA_Y = pixOut.y;
	assign VGA_COLOR = pixOut.color;

endmodule

//--- logic/tileDisplay.sv
`timescale 1ns/100ps

module tileDisplay
(
	input logic CLOCK_50,
	input logic rst,
	input logic [7:0] SW,
	output tilePkg::xCoord_t VGA_X,
	output tilePkg::yCoord_t VGA_Y,
	output tilePkg::color_t VGA_COLOR,
	output logic plot
);

	logic running;
	logic stepPending;
	logic stepAck;
	tilePkg::tileArray_t tiles;

	tilePkg::spanCmd_t span;
	logic spanValid;
	logic spanBusy;

	// SW[0] is the game-on switch
	tileMotion u_tileMotion
	(
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.gameSwitch(SW[0]),
		.stepAck(stepAck),
		.running(running),
		.stepPending(stepPending),
		.tiles(tiles)
	);

	drawSequencer u_drawSequencer
	(
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.running(running),
		.stepPending(stepPending),
		.tiles(tiles),
		.spanBusy(spanBusy),
		.span(span),
		.spanValid(spanValid),
		.stepAck(stepAck)
	);

	spanRasterizer u_spanRasterizer
	(
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.span(span),
		.spanValid(spanValid),
		.spanBusy(spanBusy),
		.VGA_X(VGA_X),
		.VGA_Y(VGA_Y),
		.VGA_COLOR(VGA_COLOR),
		.plot(plot)
	);

endmodule

//--- logic/tileMotion.sv
`timescale 1ns/100ps

module tileMotion
(
	input logic CLOCK_50,
	input logic rst,
	input logic gameSwitch,
	input logic stepAck,
	output logic running,
	output logic stepPending,
	output tilePkg::tileArray_t tiles
);

	logic switchMeta;
	logic [$bits(tilePkg::StepPeriod)-1:0] stepCount;
	tilePkg::lane_t laneReg [tilePkg::NumTiles];
	tilePkg::yCoord_t topReg [tilePkg::NumTiles];

	// Two-stage synchronizer for the game switch
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			switchMeta <= 1'b0;
			running <= 1'b0;
		end
		else
		begin
			switchMeta <= gameSwitch;
			running <= switchMeta;
		end
	end

	// Step timer, frozen while paused or while a step is outstanding
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			stepCount <= '0;
			stepPending <= 1'b0;
		end
		else if (stepAck)
		begin
			stepCount <= '0;
			stepPending <= 1'b0;
		end
		else if (running && !stepPending)
		begin
			stepCount <= stepCount + 1'b1;
			if (stepCount == tilePkg::StepPeriod - 1'b1)
				stepPending <= 1'b1;
		end
	end

	// All tiles advance together on the ack
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			for (int i = 0; i < tilePkg::NumTiles; i++)
			begin
				laneReg[i] <= tilePkg::lane_t'(i);
				topReg[i] <= tilePkg::yCoord_t'(i * tilePkg::StartStagger);
			end
		end
		else if (stepAck)
		begin
			for (int i = 0; i < tilePkg::NumTiles; i++)
			begin
				if (tiles[i].atBottom)
				begin
					// Wrap to the top of the next lane
					topReg[i] <= '0;
					laneReg[i] <= laneReg[i] + 1'b1;
				end
				else
					topReg[i] <= topReg[i] + 1'b1;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < tilePkg::NumTiles; i++)
		begin
			tiles[i].lane = laneReg[i];
			tiles[i].top = topReg[i];
			tiles[i].atBottom = (topReg[i] == tilePkg::LastTop);
		end
	end

endmodule

//--- logic/tilePkg.sv
package tilePkg;

	// Meaningful widths
	typedef logic [7:0] xCoord_t;
	typedef logic [6:0] yCoord_t;
	typedef logic [2:0] color_t;
	typedef logic [1:0] lane_t;
	typedef logic [7:0] spanLen_t;

	// Screen geometry
	localparam xCoord_t ScreenWidth = 8'd160;
	localparam yCoord_t ScreenHeight = 7'd120;
	localparam spanLen_t BorderWidth = 8'd4;
	localparam spanLen_t LaneWidth = 8'd35;

	// Tile shape and motion
	localparam spanLen_t TileWidth = 8'd35;
	localparam yCoord_t TileHeight = 7'd20;
	localparam int NumTiles = 4;
	localparam int StartStagger = 30;
	localparam logic [11:0] StepPeriod = 12'd4000;
	localparam yCoord_t LastTop = ScreenHeight - TileHeight;

	// 3-bit RGB
	localparam color_t ColorBlack = 3'b000;
	localparam color_t ColorBorder = 3'b010;
	localparam color_t ColorTile = 3'b111;

	// Horizontal run of a single color
	typedef struct packed
	{
		xCoord_t xStart;
		yCoord_t y;
		spanLen_t len;
		color_t color;
	} spanCmd_t;

	typedef struct packed
	{
		xCoord_t x;
		yCoord_t y;
		color_t color;
	} pixel_t;

	// atBottom is set when top reaches LastTop
	typedef struct packed
	{
		lane_t lane;
		yCoord_t top;
		logic atBottom;
	} tileState_t;

	typedef tileState_t [NumTiles-1:0] tileArray_t;

	typedef enum logic [2:0]
	{
		IDLE,
		BACKGROUND,
		INITDRAW,
		WAITSTEP,
		ERASE,
		DRAW,
		ACK
	} seqState_t;

endpackage

//--- vlog.f
logic/tilePkg.sv
logic/tileMotion.sv
logic/drawSequencer.sv
logic/spanRasterizer.sv
logic/tileDisplay.sv
dv/tileDisplay_assertions.sv
dv/tileDisplayTb.sv
